/* common/id_pkg.sv */
// RV64I decode-stage types; covers LUI, OP-IMM, OP, LOAD, STORE, BRANCH, JAL, JALR only (no CSR or *W ops)
package id_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int GPR_ADDR_W = 5;
  localparam int NUM_GPR    = 32;

  // major opcodes of the decoded subset
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef enum logic [3:0] {
    ALU_ADD      = 4'd0,
    ALU_SUB      = 4'd1,
    ALU_SLL      = 4'd2,
    ALU_SLT      = 4'd3,
    ALU_SLTU     = 4'd4,
    ALU_XOR      = 4'd5,
    ALU_SRL      = 4'd6,
    ALU_SRA      = 4'd7,
    ALU_OR       = 4'd8,
    ALU_AND      = 4'd9,
    ALU_PASS_IMM = 4'd10   // lui
  } alu_op_e;

  // msb set = control transfer, low 3 bits follow branch funct3
  // jal/jalr sit on the funct3 codes that branches leave unused
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_BEQ  = 4'b1000,
    BR_BNE  = 4'b1001,
    BR_JAL  = 4'b1010,
    BR_JALR = 4'b1011,
    BR_BLT  = 4'b1100,
    BR_BGE  = 4'b1101,
    BR_BLTU = 4'b1110,
    BR_BGEU = 4'b1111
  } br_func_e;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic [GPR_ADDR_W-1:0] rd;     // zero: nothing to forward
    logic [XLEN-1:0]       result;
  } bypass_t;

  typedef struct packed {
    logic                  wen;
    logic [GPR_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } ws_to_rf_t;

  typedef struct packed {
    alu_op_e    alu_op;
    br_func_e   br_func;
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;    // funct3 of load/store
    logic       load_sel;
    logic       invalid;
  } dec_ctrl_t;

  typedef struct packed {
    dec_ctrl_t             ctrl;
    logic [XLEN-1:0]       rs1data;
    logic [XLEN-1:0]       rs2data;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [GPR_ADDR_W-1:0] rd;
  } ds_to_es_t;

  typedef struct packed {
    logic            stall;
    logic            taken;
    logic [XLEN-1:0] target;
  } br_t;

endpackage

/* src/id_pipe_ctrl.sv */
// stage register and handshake; load-use check compares raw rs1/rs2 fields, even if unused by the op
module id_pipe_ctrl #(
  parameter int NUM_BYPASS = 3
) (
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  input  logic                          i_fs_valid,
  input  id_pkg::fs_to_ds_t             i_fs_bus,
  input  logic                          i_es_allowin,
  input  logic                          i_es_load_sel,
  input  id_pkg::bypass_t               i_es_bypass,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_rs1,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_rs2,
  output logic                          o_ds_allowin,
  output logic                          o_ds_valid,
  output logic                          o_ds_to_es_valid,
  output logic                          o_stall,
  output id_pkg::fs_to_ds_t             o_ds_bus
);
  import id_pkg::*;

  logic      ds_valid_q;
  fs_to_ds_t ds_bus_q;
  logic      load_stall;
  logic      ready_go;

  // the load-use check reads bypass entry 0, so execute has to exist
  if (NUM_BYPASS < 1) begin : g_bypass_chk
    $error("id_pipe_ctrl: NUM_BYPASS must include the execute entry");
  end

  // load result is not ready until it reaches memory
  assign load_stall = i_es_load_sel && (i_es_bypass.rd != '0) &&
                      ((i_es_bypass.rd == i_rs1) || (i_es_bypass.rd == i_rs2));

  assign ready_go         = !load_stall;
  assign o_ds_allowin     = !ds_valid_q || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid_q && ready_go;
  assign o_ds_valid       = ds_valid_q;
  assign o_stall          = load_stall;
  assign o_ds_bus         = ds_bus_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid_q <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid_q <= i_fs_valid;   // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_bus_q <= '0;
    end else if (i_fs_valid && o_ds_allowin) begin
      ds_bus_q <= i_fs_bus;
    end
  end

endmodule

/* src/id_gpr_file.sv */
// 32 x 64-bit register file; a write shows on the read ports from the next cycle only
module id_gpr_file (
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_raddr1,
  input  logic [id_pkg::GPR_ADDR_W-1:0] i_raddr2,
  input  id_pkg::ws_to_rf_t             i_wr,
  output logic [id_pkg::XLEN-1:0]       o_rdata1,
  output logic [id_pkg::XLEN-1:0]       o_rdata2
);
  import id_pkg::*;

  logic [XLEN-1:0] regs [NUM_GPR];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && (i_wr.waddr != '0)) begin   // x0 is hardwired
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // no write-through, bypass covers the write-back cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* decode/id_decoder.sv */
// RV64I subset decoder; other opcodes flag invalid, branch funct3 010/011 decode as no branch
module id_decoder (
  input  logic [id_pkg::INST_W-1:0]     i_inst,
  output logic [id_pkg::GPR_ADDR_W-1:0] o_rs1,
  output logic [id_pkg::GPR_ADDR_W-1:0] o_rs2,
  output logic [id_pkg::GPR_ADDR_W-1:0] o_rd,
  output logic [id_pkg::XLEN-1:0]       o_imm,
  output id_pkg::dec_ctrl_t             o_ctrl
);
  import id_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  // funct3 to alu op; alt picks sub/sra
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rd   = i_inst[11:7];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.alu_op  = ALU_ADD;
    o_ctrl.br_func = BR_NONE;
    o_imm          = '0;
    case (opcode)
      OPC_LUI: begin
        o_imm          = imm_u;
        o_ctrl.alu_op  = ALU_PASS_IMM;
        o_ctrl.gpr_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        o_imm          = imm_i;
        o_ctrl.alu_op  = alu_sel(funct3, (funct3 == 3'b101) && funct7[5]);  // no subi
        o_ctrl.gpr_wen = 1'b1;
      end
      OPC_OP: begin
        o_ctrl.alu_op  = alu_sel(funct3, funct7[5]);
        o_ctrl.gpr_wen = 1'b1;
      end
      OPC_LOAD: begin
        o_imm           = imm_i;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.mem_op   = funct3;
        o_ctrl.load_sel = 1'b1;
      end
      OPC_STORE: begin
        o_imm          = imm_s;
        o_ctrl.mem_wen = 1'b1;
        o_ctrl.mem_op  = funct3;
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        if (funct3[2:1] != 2'b01) begin
          o_ctrl.br_func = br_func_e'({1'b1, funct3});
        end
      end
      OPC_JAL: begin
        o_imm          = imm_j;
        o_ctrl.br_func = BR_JAL;
        o_ctrl.gpr_wen = 1'b1;   // link
      end
      OPC_JALR: begin
        o_imm          = imm_i;
        o_ctrl.br_func = BR_JALR;
        o_ctrl.gpr_wen = 1'b1;
      end
      default: o_ctrl.invalid = 1'b1;
    endcase
  end

endmodule

/* decode/id_operand_fwd.sv */
// one source operand's bypass mux; entry 0 has top priority and rd zero never forwards
module id_operand_fwd #(
  parameter int NUM_BYPASS = 3
) (
  input  logic [id_pkg::GPR_ADDR_W-1:0]  i_rs,
  input  logic [id_pkg::XLEN-1:0]        i_rf_data,
  input  id_pkg::bypass_t [NUM_BYPASS-1:0] i_bypass,
  output logic [id_pkg::XLEN-1:0]        o_data
);

  logic [NUM_BYPASS-1:0] hit;

  always_comb begin
    for (int i = 0; i < NUM_BYPASS; i++) begin
      hit[i] = (i_bypass[i].rd != '0) && (i_bypass[i].rd == i_rs);
    end
  end

  // walk oldest to youngest so the lowest index lands last
  always_comb begin
    o_data = i_rf_data;
    for (int i = NUM_BYPASS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        o_data = i_bypass[i].result;
      end
    end
  end

endmodule

/* src/id_branch_unit.sv */
// branch/jump resolve in decode; taken only with a valid stage, stall flags a redirect under load-use
module id_branch_unit (
  input  logic                    i_valid,
  input  logic                    i_stall,
  input  id_pkg::br_func_e        i_br_func,
  input  logic [id_pkg::XLEN-1:0] i_rs1data,
  input  logic [id_pkg::XLEN-1:0] i_rs2data,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_imm,
  output id_pkg::br_t             o_br
);
  import id_pkg::*;

  logic            cond;
  logic [XLEN-1:0] jalr_sum;

  always_comb begin
    case (i_br_func)
      BR_BEQ:           cond = (i_rs1data == i_rs2data);
      BR_BNE:           cond = (i_rs1data != i_rs2data);
      BR_BLT:           cond = ($signed(i_rs1data) < $signed(i_rs2data));
      BR_BGE:           cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      BR_BLTU:          cond = (i_rs1data < i_rs2data);
      BR_BGEU:          cond = (i_rs1data >= i_rs2data);
      BR_JAL, BR_JALR:  cond = 1'b1;
      default:          cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1data + i_imm;

  assign o_br.taken  = i_valid && cond;
  assign o_br.stall  = o_br.taken && i_stall;   // target not trustworthy yet
  assign o_br.target = (i_br_func == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                              : (i_pc + i_imm);

endmodule

/* src/id_stage.sv */
// decode stage top; bypass entry 0 must be execute, 1 memory, 2 write-back (lower index wins)
module id_stage #(
  parameter int NUM_BYPASS = 3
) (
  input  logic                                i_clk,
  input  logic                                i_arst_n,
  // fetch side
  input  logic                                i_fs_valid,
  input  id_pkg::fs_to_ds_t                   i_fs_bus,
  output logic                                o_ds_allowin,
  // execute side
  input  logic                                i_es_allowin,
  input  logic                                i_es_load_sel,   // execute holds a load
  output logic                                o_ds_to_es_valid,
  output id_pkg::ds_to_es_t                   o_ds_to_es_bus,
  // write-back and bypass
  input  id_pkg::ws_to_rf_t                   i_ws_to_rf,
  input  id_pkg::bypass_t [NUM_BYPASS-1:0]    i_bypass,
  // redirect to fetch
  output id_pkg::br_t                         o_br
);
  import id_pkg::*;

  fs_to_ds_t                   ds_bus;
  logic                        ds_valid;
  logic                        ds_stall;
  logic [GPR_ADDR_W-1:0]       rs1;
  logic [GPR_ADDR_W-1:0]       rs2;
  logic [GPR_ADDR_W-1:0]       rd;
  logic [XLEN-1:0]             imm;
  dec_ctrl_t                   ctrl;
  logic [1:0][GPR_ADDR_W-1:0]  rs_addr;   // [0] rs1, [1] rs2
  logic [1:0][XLEN-1:0]        rf_data;
  logic [1:0][XLEN-1:0]        fwd_data;

  id_pipe_ctrl #(
    .NUM_BYPASS       (NUM_BYPASS)
  ) u_pipe_ctrl (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_fs_valid       (i_fs_valid),
    .i_fs_bus         (i_fs_bus),
    .i_es_allowin     (i_es_allowin),
    .i_es_load_sel    (i_es_load_sel),
    .i_es_bypass      (i_bypass[0]),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_stall          (ds_stall),
    .o_ds_bus         (ds_bus)
  );

  id_decoder u_decoder (
    .i_inst (ds_bus.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_ctrl (ctrl)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wr     (i_ws_to_rf),
    .o_rdata1 (rf_data[0]),
    .o_rdata2 (rf_data[1])
  );

  assign rs_addr = {rs2, rs1};

  for (genvar g = 0; g < 2; g++) begin : g_fwd
    id_operand_fwd #(
      .NUM_BYPASS (NUM_BYPASS)
    ) u_operand_fwd (
      .i_rs       (rs_addr[g]),
      .i_rf_data  (rf_data[g]),
      .i_bypass   (i_bypass),
      .o_data     (fwd_data[g])
    );
  end

  id_branch_unit u_branch_unit (
    .i_valid    (ds_valid),
    .i_stall    (ds_stall),
    .i_br_func  (ctrl.br_func),
    .i_rs1data  (fwd_data[0]),
    .i_rs2data  (fwd_data[1]),
    .i_pc       (ds_bus.pc),
    .i_imm      (imm),
    .o_br       (o_br)
  );

  assign o_ds_to_es_bus.ctrl    = ctrl;
  assign o_ds_to_es_bus.rs1data = fwd_data[0];
  assign o_ds_to_es_bus.rs2data = fwd_data[1];
  assign o_ds_to_es_bus.imm     = imm;
  assign o_ds_to_es_bus.pc      = ds_bus.pc;
  assign o_ds_to_es_bus.rd      = rd;

endmodule

/* test/tb_clock_gen.sv */
// free-running testbench clock; period in ns, starts low
module tb_clock_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

endmodule

/* test/id_stage_assert.sv */
// handshake properties for id_stage; stable-bus check assumes bypass and rf inputs hold under stall
module id_stage_assert (
  input logic              i_clk,
  input logic              i_arst_n,
  input logic              i_es_allowin,
  input logic              o_ds_allowin,
  input logic              o_ds_to_es_valid,
  input id_pkg::ds_to_es_t o_ds_to_es_bus,
  input logic              i_ds_valid,
  input logic              i_ds_stall
);
  timeunit 1ns;
  timeprecision 100ps;

  a_no_valid_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !o_ds_to_es_valid)
    else $error("output valid high during reset");

  // execute not taking it, so the payload must hold
  a_bus_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> $stable(o_ds_to_es_bus))
    else $error("decode bus changed under back-pressure");

  a_no_allowin_on_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_ds_valid && i_ds_stall) |-> !o_ds_allowin)
    else $error("allowin high during load-use stall");

endmodule

/* test/id_stage_tb.sv */
// self-checking testbench for id_stage; 3 bypass entries, random stimulus from a fixed LCG seed
module id_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import id_pkg::*;

  localparam int NUM_BYPASS = 3;
  localparam int NUM_TESTS  = 32 + 40 + 40 + 6 + 48 + 40 + 20;
  localparam int CYCLE_LIMIT = NUM_TESTS * 20 + 200;

  logic                      i_clk;
  logic                      i_arst_n;
  logic                      i_fs_valid;
  fs_to_ds_t                 i_fs_bus;
  logic                      o_ds_allowin;
  logic                      i_es_allowin;
  logic                      i_es_load_sel;
  logic                      o_ds_to_es_valid;
  ds_to_es_t                 o_ds_to_es_bus;
  ws_to_rf_t                 i_ws_to_rf;
  bypass_t [NUM_BYPASS-1:0]  i_bypass;
  br_t                       o_br;

  logic [XLEN-1:0] shadow [NUM_GPR];
  fs_to_ds_t       exp_q [$];
  logic [31:0]     seed    = 32'h4771;
  logic [31:0]     bp_seed = 32'h4771 ^ 32'h5a5a;
  logic            bp_en   = 1'b0;
  int              bp_hold = 0;
  int              cycles  = 0;

  tb_clock_gen #(.PERIOD_NS(4)) u_clock_gen (.o_clk(i_clk));

  id_stage #(.NUM_BYPASS(NUM_BYPASS)) u_id_stage (.*);

  bind id_stage id_stage_assert u_assert (
    .i_clk, .i_arst_n, .i_es_allowin, .o_ds_allowin, .o_ds_to_es_valid, .o_ds_to_es_bus,
    .i_ds_valid (ds_valid),
    .i_ds_stall (ds_stall)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    seed = lcg_next(seed);
    return seed;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic value_error(input string field, input logic [XLEN-1:0] exp, got);
    abort_run($sformatf("[ERROR] %0t ns: %s expected %h got %h", $time, field, exp, got));
  endtask

  // rd zero never forwards, lowest index first, then the register copy
  function automatic logic [XLEN-1:0] ref_operand(input logic [4:0] rs);
    for (int i = 0; i < NUM_BYPASS; i++) begin
      if (i_bypass[i].rd != 5'd0 && i_bypass[i].rd == rs) return i_bypass[i].result;
    end
    return shadow[rs];
  endfunction

  function automatic alu_op_e ref_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return alt ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic void ref_model(input fs_to_ds_t f, output ds_to_es_t e, output br_t b);
    logic [31:0] in;
    logic [2:0]  f3;
    logic        cond;
    in = f.inst;
    f3 = in[14:12];
    e = '0;
    e.ctrl.alu_op  = ALU_ADD;
    e.ctrl.br_func = BR_NONE;
    e.pc      = f.pc;
    e.rd      = in[11:7];
    e.rs1data = ref_operand(in[19:15]);
    e.rs2data = ref_operand(in[24:20]);
    case (in[6:0])
      OPC_LUI: begin
        e.imm = 64'($signed({in[31:12], 12'h000}));
        e.ctrl.alu_op = ALU_PASS_IMM;
        e.ctrl.gpr_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        e.imm = 64'($signed(in[31:20]));
        e.ctrl.alu_op = ref_alu(f3, f3 == 3'd5 && in[30]);
        e.ctrl.gpr_wen = 1'b1;
      end
      OPC_OP: begin
        e.ctrl.alu_op = ref_alu(f3, in[30]);
        e.ctrl.gpr_wen = 1'b1;
      end
      OPC_LOAD: begin
        e.imm = 64'($signed(in[31:20]));
        e.ctrl.gpr_wen  = 1'b1;
        e.ctrl.mem_ren  = 1'b1;
        e.ctrl.load_sel = 1'b1;
        e.ctrl.mem_op   = f3;
      end
      OPC_STORE: begin
        e.imm = 64'($signed({in[31:25], in[11:7]}));
        e.ctrl.mem_wen = 1'b1;
        e.ctrl.mem_op  = f3;
      end
      OPC_BRANCH: begin
        e.imm = 64'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
        case (f3)
          3'd0: e.ctrl.br_func = BR_BEQ;
          3'd1: e.ctrl.br_func = BR_BNE;
          3'd4: e.ctrl.br_func = BR_BLT;
          3'd5: e.ctrl.br_func = BR_BGE;
          3'd6: e.ctrl.br_func = BR_BLTU;
          3'd7: e.ctrl.br_func = BR_BGEU;
          default: e.ctrl.br_func = BR_NONE;
        endcase
      end
      OPC_JAL: begin
        e.imm = 64'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
        e.ctrl.br_func = BR_JAL;
        e.ctrl.gpr_wen = 1'b1;
      end
      OPC_JALR: begin
        e.imm = 64'($signed(in[31:20]));
        e.ctrl.br_func = BR_JALR;
        e.ctrl.gpr_wen = 1'b1;
      end
      default: e.ctrl.invalid = 1'b1;
    endcase
    case (e.ctrl.br_func)
      BR_BEQ:  cond = e.rs1data == e.rs2data;
      BR_BNE:  cond = e.rs1data != e.rs2data;
      BR_BLT:  cond = $signed(e.rs1data) < $signed(e.rs2data);
      BR_BGE:  cond = !($signed(e.rs1data) < $signed(e.rs2data));
      BR_BLTU: cond = e.rs1data < e.rs2data;
      BR_BGEU: cond = !(e.rs1data < e.rs2data);
      BR_JAL, BR_JALR: cond = 1'b1;
      default: cond = 1'b0;
    endcase
    b.taken  = cond;
    b.stall  = 1'b0;   // a transfer means no load-use stall
    b.target = (e.ctrl.br_func == BR_JALR) ? ((e.rs1data + e.imm) & ~64'd1) : (f.pc + e.imm);
  endfunction

  task automatic check_ds_to_es(input ds_to_es_t exp, input ds_to_es_t got);
    if (got.ctrl !== exp.ctrl) value_error("ctrl", 64'(exp.ctrl), 64'(got.ctrl));
    if (got.rs1data !== exp.rs1data) value_error("rs1data", exp.rs1data, got.rs1data);
    if (got.rs2data !== exp.rs2data) value_error("rs2data", exp.rs2data, got.rs2data);
    if (got.imm !== exp.imm) value_error("imm", exp.imm, got.imm);
    if (got.pc !== exp.pc) value_error("pc", exp.pc, got.pc);
    if (got.rd !== exp.rd) value_error("rd", 64'(exp.rd), 64'(got.rd));
  endtask

  task automatic check_br(input br_t exp, input br_t got);
    if (got.taken !== exp.taken) value_error("br taken", 64'(exp.taken), 64'(got.taken));
    if (got.stall !== exp.stall) value_error("br stall", 64'(exp.stall), 64'(got.stall));
    if (exp.taken && got.target !== exp.target) value_error("br target", exp.target, got.target);
  endtask

  // compare at negedge, where everything driven after posedge has settled
  always @(negedge i_clk) begin
    fs_to_ds_t f;
    ds_to_es_t e;
    br_t       b;
    if (i_arst_n && o_ds_to_es_valid && i_es_allowin) begin
      if (exp_q.size() == 0) abort_run("decode sent an instruction that was never issued");
      f = exp_q.pop_front();
      ref_model(f, e, b);
      check_ds_to_es(e, o_ds_to_es_bus);
      check_br(b, o_br);
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) abort_run("timeout: the run took too many cycles");
  end

  // random back-pressure stretches of 1 to 4 cycles
  always @(posedge i_clk) begin
    #1;
    if (!bp_en) begin
      i_es_allowin = 1'b1;
    end else if (bp_hold == 0) begin
      bp_seed = lcg_next(bp_seed);
      i_es_allowin = bp_seed[20];
      bp_hold = bp_seed[25:24];
    end else begin
      bp_hold--;
    end
  end

  task automatic send(input logic [31:0] inst);
    i_fs_valid   = 1'b1;
    i_fs_bus.inst = inst;
    i_fs_bus.pc   = {rand32(), rand32()} & ~64'd3;
    forever begin
      @(negedge i_clk);
      if (o_ds_allowin) break;
    end
    exp_q.push_back(i_fs_bus);
    @(posedge i_clk);
    #1;
    i_fs_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge i_clk);
    #1;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
    i_ws_to_rf = '{wen: 1'b1, waddr: addr, wdata: data};
    if (addr != 5'd0) shadow[addr] = data;
    @(posedge i_clk);
    #1;
    i_ws_to_rf.wen = 1'b0;
  endtask

  function automatic logic [31:0] rand_alu_mem();
    logic [31:0] r;
    r = rand32();
    case (r[2:0] % 5)
      0: return {r[31:7], OPC_LUI};
      1: return {r[31:7], OPC_OP_IMM};
      2: return {r[31:7], OPC_OP};
      3: return {r[31:7], OPC_LOAD};
      default: return {r[31:7], OPC_STORE};
    endcase
  endfunction

  function automatic bypass_t rand_bypass(input logic [4:0] rs1, rs2);
    logic [31:0] r;
    r = rand32();
    case (r[1:0])
      0: return '{rd: 5'd0, result: {rand32(), rand32()}};
      1: return '{rd: rs1, result: {rand32(), rand32()}};
      2: return '{rd: rs2, result: {rand32(), rand32()}};
      default: return '{rd: r[12:8], result: {rand32(), rand32()}};
    endcase
  endfunction

  initial begin
    logic [31:0] inst;
    logic [31:0] r;
    logic [6:0]  opc;
    i_arst_n = 1'b0;
    i_fs_valid = 1'b0;
    i_fs_bus = '0;
    i_es_allowin = 1'b1;
    i_es_load_sel = 1'b0;
    i_ws_to_rf = '0;
    i_bypass = '0;
    for (int i = 0; i < NUM_GPR; i++) shadow[i] = '0;
    repeat (10) @(posedge i_clk);
    #1 i_arst_n = 1'b1;
    @(negedge i_clk);
    if (!o_ds_allowin || o_ds_to_es_valid || o_br.taken)
      abort_run("handshake outputs are wrong right after reset");
    @(posedge i_clk);
    #1;

    // register file path, x0 write must be dropped
    for (int i = 0; i < NUM_GPR; i++) write_reg(i[4:0], {rand32(), rand32()});
    for (int i = 0; i < 40; i++) begin
      inst = rand_alu_mem();
      if (i == 0) inst[24:15] = '0;   // both sources on x0
      send(inst);
      wait_drain();
    end

    // forwarding priority
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      inst = {7'd0, r[24:7], OPC_OP};
      if (i % 8 == 0) inst[19:15] = 5'd0;   // rd zero entries must not hit
      for (int k = 0; k < NUM_BYPASS; k++) i_bypass[k] = rand_bypass(inst[19:15], inst[24:20]);
      send(inst);
      wait_drain();
    end
    i_bypass = '0;

    // load-use stall
    for (int i = 0; i < 6; i++) begin
      r = rand32();
      inst = {r[31:20], 5'd1 + 5'(i), 3'd0, 5'd7, (i < 3) ? OPC_OP : OPC_JALR};
      i_es_load_sel = 1'b1;
      i_bypass[0] = '{rd: (i % 2 == 0) ? inst[19:15] : inst[24:20], result: {rand32(), rand32()}};
      if (i_bypass[0].rd == 5'd0) i_bypass[0].rd = inst[19:15];
      send(inst);
      repeat (3 + i) begin
        @(negedge i_clk);
        if (o_ds_to_es_valid || o_ds_allowin) abort_run("decode moved on during a load-use stall");
        if (o_br.stall !== (inst[6:0] == OPC_JALR))
          value_error("br stall in load-use", 64'(inst[6:0] == OPC_JALR), 64'(o_br.stall));
      end
      @(posedge i_clk);
      #1 i_es_load_sel = 1'b0;
      wait_drain();
    end
    i_bypass = '0;

    // branches, jal and jalr
    for (int i = 0; i < 48; i++) begin
      inst = rand32();
      case (i % 8)
        6: inst[6:0] = OPC_JAL;
        7: begin
          inst[6:0] = OPC_JALR;
          inst[14:12] = 3'd0;
        end
        default: begin
          inst[6:0] = OPC_BRANCH;
          inst[14:12] = (i % 8 < 2) ? 3'(i % 8) : 3'(i % 8 + 2);
        end
      endcase
      i_bypass[2] = '{rd: inst[19:15], result: {rand32(), rand32()}};
      i_bypass[1] = '{rd: inst[24:20], result: i[3] ? i_bypass[2].result : {rand32(), rand32()}};
      send(inst);
      wait_drain();
      @(negedge i_clk);
      if (o_br.taken) abort_run("branch taken while the stage was empty");
      @(posedge i_clk);
      #1;
    end
    i_bypass = '0;

    // back-pressure, issued back to back
    bp_en = 1'b1;
    for (int i = 0; i < 40; i++) send(rand_alu_mem());
    wait_drain();
    bp_en = 1'b0;

    // opcodes outside the subset
    for (int i = 0; i < 20; i++) begin
      inst = rand32();
      opc = inst[6:0];
      while (opc == OPC_LUI || opc == OPC_OP_IMM || opc == OPC_OP || opc == OPC_LOAD ||
             opc == OPC_STORE || opc == OPC_BRANCH || opc == OPC_JAL || opc == OPC_JALR) begin
        opc = opc + 7'd1;
      end
      inst[6:0] = opc;
      send(inst);
      wait_drain();
    end

    repeat (4) @(posedge i_clk);
    if (exp_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("instructions were issued but never reached execute");
    end
  end

endmodule

/* files.f */
common/id_pkg.sv
src/id_pipe_ctrl.sv
src/id_gpr_file.sv
decode/id_decoder.sv
decode/id_operand_fwd.sv
src/id_branch_unit.sv
src/id_stage.sv
test/tb_clock_gen.sv
test/id_stage_assert.sv
test/id_stage_tb.sv
